// ==== compile.f ====
+incdir+verilog
verilog/cache_addr_pkg.sv
verilog/cache_req_pkg.sv
verilog/dual_port_blockram.sv
verilog/cache_lookup.sv
verilog/cache_write_arbiter.sv
verilog/cache_top.sv
tests/cache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the cache testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module cache_tb \
    -o cache_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/cache_sim > sim.log 2>&1
cat sim.log

grep -q "ALL TESTS PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// ==== tests/cache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cache_tb;

typedef struct packed
{
    logic                               valid;
    logic                               hit;
    logic                               is_load;
    logic [31 : 0]                      addr;
    logic [`LINE_WIDTH_IN_BITS - 1 : 0] line;
} expect_t;

localparam logic [`TAG_WIDTH - 1 : 0] TAG_A = 23'h012345;
localparam logic [`TAG_WIDTH - 1 : 0] TAG_B = 23'h054321;

logic                        clk_in;
logic                        reset_in;
logic                        req_valid;
cache_req_pkg::cache_req_t   req;
logic                        fill_valid;
cache_req_pkg::cache_fill_t  fill;
logic                        resp_valid;
cache_req_pkg::cache_resp_t  resp;

// shadow of the cache contents.
logic                               model_valid [0 : `NUM_SET - 1];
logic [`TAG_WIDTH - 1 : 0]          model_tag   [0 : `NUM_SET - 1];
logic [`LINE_WIDTH_IN_BITS - 1 : 0] model_line  [0 : `NUM_SET - 1];
int                                 busy_until  [0 : `NUM_SET - 1];

expect_t       exp_in;
expect_t       exp_mid;
expect_t       exp_out; // lines up with resp.
logic [31 : 0] lfsr_state;
int            error_count;
int            timeout_count;
int            cycle_count;
string         test_name;

cache_top cache_top_inst
(
    .clk_in     (clk_in),
    .reset_in   (reset_in),
    .req_valid  (req_valid),
    .req        (req),
    .fill_valid (fill_valid),
    .fill       (fill),
    .resp_valid (resp_valid),
    .resp       (resp)
);

initial
begin
    clk_in = 1'b0;
    forever #5 clk_in = ~clk_in;
end

always @(posedge clk_in)
begin
    if (reset_in)
    begin
        exp_mid <= '0;
        exp_out <= '0;
    end
    else
    begin
        exp_mid <= exp_in;
        exp_out <= exp_mid;
    end
end

resp_timing : assert property (@(posedge clk_in) disable iff (reset_in)
    resp_valid == exp_out.valid)
else
begin
    error_count++;
    $display("Error: %s resp_valid expected %0b actual %0b", test_name,
             $sampled(exp_out.valid), $sampled(resp_valid));
end

resp_hit : assert property (@(posedge clk_in) disable iff (reset_in)
    (resp_valid && exp_out.valid) |-> (resp.hit == exp_out.hit))
else
begin
    error_count++;
    $display("Error: %s hit expected %0b actual %0b", test_name,
             $sampled(exp_out.hit), $sampled(resp.hit));
end

resp_addr : assert property (@(posedge clk_in) disable iff (reset_in)
    (resp_valid && exp_out.valid) |-> (resp.addr.raw == exp_out.addr))
else
begin
    error_count++;
    $display("Error: %s addr expected %h actual %h", test_name,
             $sampled(exp_out.addr), $sampled(resp.addr.raw));
end

load_line : assert property (@(posedge clk_in) disable iff (reset_in)
    (resp_valid && exp_out.valid && exp_out.is_load && exp_out.hit)
    |-> (resp.line == exp_out.line))
else
begin
    error_count++;
    $display("Error: %s line expected %h actual %h", test_name,
             $sampled(exp_out.line), $sampled(resp.line));
end

// taps 32, 22, 2, 1.
function automatic logic [31 : 0] lfsr_take(input int nbits);
    logic [31 : 0] val;
    logic          fb;
    val = '0;
    for (int i = 0; i < nbits; i++)
    begin
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30 : 0], fb};
        val        = {val[30 : 0], fb};
    end
    return val;
endfunction

function automatic logic [31 : 0] make_addr(input logic [`TAG_WIDTH - 1 : 0] tag,
                                            input logic [`INDEX_WIDTH - 1 : 0] index,
                                            input logic [`OFFSET_WIDTH - 1 : 0] offset);
    return {tag, index, offset};
endfunction

function automatic logic [`TAG_WIDTH - 1 : 0] pool_tag(input logic [1 : 0] pick);
    return 23'h2b4c00 + {21'd0, pick};
endfunction

function automatic cache_req_pkg::cache_req_t make_req(input logic is_store,
                                                      input logic [31 : 0] addr,
                                                      input logic [63 : 0] data,
                                                      input logic [7 : 0] byte_en);
    cache_req_pkg::cache_req_t r;
    r.op       = is_store ? cache_req_pkg::CACHE_STORE : cache_req_pkg::CACHE_LOAD;
    r.addr.raw = addr;
    r.data     = data;
    r.byte_en  = byte_en;
    return r;
endfunction

// one drive cycle; the model sees the fill before the request.
task automatic issue(input logic do_fill, input logic [31 : 0] fill_addr,
                     input logic [63 : 0] fill_data, input logic do_req,
                     input cache_req_pkg::cache_req_t r);
    expect_t                     e;
    cache_req_pkg::cache_fill_t  f;
    logic [`INDEX_WIDTH - 1 : 0] idx;
    logic [`TAG_WIDTH - 1 : 0]   tag;
    e          = '0;
    f.addr.raw = fill_addr;
    f.line     = fill_data;
    if (do_fill)
    begin
        idx              = fill_addr[`OFFSET_WIDTH +: `INDEX_WIDTH];
        model_valid[idx] = 1'b1;
        model_tag[idx]   = fill_addr[31 -: `TAG_WIDTH];
        model_line[idx]  = fill_data;
    end
    if (do_req)
    begin
        idx       = r.addr.raw[`OFFSET_WIDTH +: `INDEX_WIDTH];
        tag       = r.addr.raw[31 -: `TAG_WIDTH];
        e.valid   = 1'b1;
        e.is_load = (r.op == cache_req_pkg::CACHE_LOAD);
        e.addr    = r.addr.raw;
        e.hit     = model_valid[idx] && (model_tag[idx] == tag);
        e.line    = model_line[idx];
        if (!e.is_load && e.hit)
        begin
            for (int b = 0; b < `LINE_BYTES; b++)
            begin
                if (r.byte_en[b])
                    model_line[idx][b * 8 +: 8] = r.data[b * 8 +: 8];
            end
        end
    end
    fill_valid <= do_fill;
    fill       <= f;
    req_valid  <= do_req;
    req        <= r;
    exp_in     <= e;
    cycle_count++;
    @(posedge clk_in);
endtask

task automatic idle(input int n);
    repeat (n) issue(1'b0, '0, '0, 1'b0, '0);
endtask

task automatic send_load(input logic [31 : 0] addr);
    issue(1'b0, '0, '0, 1'b1, make_req(1'b0, addr, '0, '0));
endtask

task automatic send_store(input logic [31 : 0] addr, input logic [63 : 0] data,
                          input logic [7 : 0] byte_en);
    issue(1'b0, '0, '0, 1'b1, make_req(1'b1, addr, data, byte_en));
endtask

task automatic send_fill(input logic [31 : 0] addr, input logic [63 : 0] data);
    issue(1'b1, addr, data, 1'b0, '0);
endtask

task automatic drain();
    int waited;
    waited = 0;
    while ((exp_in.valid || exp_mid.valid || exp_out.valid) && waited < 20)
    begin
        idle(1);
        waited++;
    end
    if (waited >= 20)
    begin
        timeout_count++;
        $display("%s: responses did not drain in time", test_name);
    end
endtask

task automatic run_random();
    int                          ops;
    int                          guard;
    logic                        do_fill;
    logic                        do_req;
    logic                        is_store;
    logic                        last_fill;
    logic [2 : 0]                store_hist; // bit n set: store issued n + 1 cycles ago.
    logic [31 : 0]               pick;
    logic [31 : 0]               hi;
    logic [31 : 0]               lo;
    logic [31 : 0]               be;
    logic [`INDEX_WIDTH - 1 : 0] idx;
    logic [31 : 0]               faddr;
    logic [63 : 0]               fline;
    cache_req_pkg::cache_req_t   r;
    ops        = 0;
    guard      = 0;
    last_fill  = 1'b0;
    store_hist = '0;
    while (ops < 300 && guard < 3000)
    begin
        do_fill  = 1'b0;
        do_req   = 1'b0;
        is_store = 1'b0;
        faddr    = '0;
        fline    = '0;
        r        = '0;
        pick     = lfsr_take(2);
        // no fill next to a full store buffer.
        if (!last_fill && !store_hist[2] && pick[1 : 0] == 2'd0)
        begin
            pick = lfsr_take(5);
            hi   = lfsr_take(32);
            lo   = lfsr_take(32);
            idx  = {3'b010, pick[2 : 0]};
            if (cycle_count >= busy_until[idx])
            begin
                do_fill = 1'b1;
                faddr   = make_addr(pool_tag(pick[4 : 3]), idx, 3'd0);
                fline   = {hi, lo};
            end
        end
        pick = lfsr_take(2);
        if (pick[1 : 0] != 2'd0)
        begin
            is_store = (pick[1 : 0] == 2'd3);
            pick     = lfsr_take(8);
            hi       = lfsr_take(32);
            lo       = lfsr_take(32);
            be       = lfsr_take(8);
            idx      = {3'b010, pick[2 : 0]};
            if (cycle_count >= busy_until[idx])
            begin
                do_req = 1'b1;
                r      = make_req(is_store, make_addr(pool_tag(pick[4 : 3]), idx, pick[7 : 5]),
                                  {hi, lo}, be[7 : 0]);
                if (is_store)
                    busy_until[idx] = cycle_count + 4; // store write lands late.
            end
        end
        last_fill  = do_fill;
        store_hist = {store_hist[1 : 0], do_req & is_store};
        if (do_fill)
            ops++;
        if (do_req)
            ops++;
        guard++;
        issue(do_fill, faddr, fline, do_req, r);
    end
    if (guard >= 3000)
    begin
        timeout_count++;
        $display("random traffic did not reach its operation count");
    end
    drain();
endtask

initial
begin
    reset_in      = 1'b1;
    req_valid     = 1'b0;
    req           = '0;
    fill_valid    = 1'b0;
    fill          = '0;
    exp_in        = '0;
    lfsr_state    = 32'h7c0f_1113;
    error_count   = 0;
    timeout_count = 0;
    cycle_count   = 0;
    test_name     = "reset";
    for (int i = 0; i < `NUM_SET; i++)
    begin
        model_valid[i] = 1'b0;
        model_tag[i]   = '0;
        model_line[i]  = '0;
        busy_until[i]  = 0;
    end
    repeat (5) @(posedge clk_in);
    reset_in <= 1'b0;

    test_name = "after_reset";
    send_load(make_addr(23'h000001, 6'd0, 3'd0));
    send_load(make_addr(23'h000001, 6'd5, 3'd2));
    send_load(make_addr(23'h7fffff, 6'd63, 3'd7));
    drain();

    test_name = "fill_then_load";
    send_fill(make_addr(TAG_A, 6'd3, 3'd0), 64'h0123_4567_89ab_cdef);
    send_load(make_addr(TAG_A, 6'd3, 3'd4));
    send_load(make_addr(TAG_B, 6'd3, 3'd4)); // same index, other tag.
    drain();

    test_name = "store_bytes";
    send_store(make_addr(TAG_A, 6'd3, 3'd1), 64'hfeed_face_dead_beef, 8'b0101_0010);
    drain();
    send_load(make_addr(TAG_A, 6'd3, 3'd0));
    send_store(make_addr(TAG_B, 6'd3, 3'd0), 64'h1111_2222_3333_4444, 8'hff);
    drain();
    send_load(make_addr(TAG_A, 6'd3, 3'd0));
    send_load(make_addr(TAG_B, 6'd3, 3'd0));
    drain();

    // store hit reaches the arbiter with the fill.
    test_name = "write_collision";
    send_store(make_addr(TAG_A, 6'd3, 3'd0), 64'h9876_5432_10fe_dcba, 8'b1000_0001);
    idle(1);
    send_fill(make_addr(TAG_B, 6'd10, 3'd0), 64'h5a5a_a5a5_0f0f_f0f0);
    drain();
    send_load(make_addr(TAG_A, 6'd3, 3'd0));
    send_load(make_addr(TAG_B, 6'd10, 3'd0));
    drain();

    test_name = "same_cycle_forwarding";
    issue(1'b1, make_addr(TAG_A, 6'd20, 3'd0), 64'hc001_d00d_4321_8765,
          1'b1, make_req(1'b0, make_addr(TAG_A, 6'd20, 3'd5), '0, '0));
    drain();

    test_name = "random_traffic";
    run_random();

    $display("checks done: %0d errors, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0)
        $display("ALL TESTS PASSED");
    else
        $display("SOME TESTS FAILED");
    $finish;
end

initial
begin
    repeat (20000) @(posedge clk_in);
    $display("simulation stopped at the cycle limit");
    $display("SOME TESTS FAILED");
    $finish;
end

endmodule

`default_nettype wire

// ==== verilog/cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cache_top
(
    input  logic                        clk_in,
    input  logic                        reset_in,

    input  logic                        req_valid,
    input  cache_req_pkg::cache_req_t   req,

    input  logic                        fill_valid,
    input  cache_req_pkg::cache_fill_t  fill,

    output logic                        resp_valid,
    output cache_req_pkg::cache_resp_t  resp
);

localparam int TAG_LANES = `TAG_ENTRY_WIDTH / `BYTE_LEN_IN_BITS;

// read side.
logic                                tag_read_en;
logic                                data_read_en;
logic [`INDEX_WIDTH - 1 : 0]         read_index;
cache_addr_pkg::tag_entry_t          tag_entry;
logic                                tag_valid;
logic [`LINE_WIDTH_IN_BITS - 1 : 0]  read_line;

// write side.
logic                                store_hit_valid;
cache_req_pkg::ram_write_t           store_write;
logic                                tag_write_en;
logic [TAG_LANES - 1 : 0]            tag_write_mask;
logic                                data_write_en;
logic [`LINE_BYTES - 1 : 0]          data_write_mask;
logic [`INDEX_WIDTH - 1 : 0]         write_index;
cache_addr_pkg::tag_entry_t          write_tag;
logic [`LINE_WIDTH_IN_BITS - 1 : 0]  write_line;

cache_lookup cache_lookup_inst
(
    .clk_in          (clk_in),
    .reset_in        (reset_in),
    .req_valid       (req_valid),
    .req             (req),
    .tag_read_en     (tag_read_en),
    .data_read_en    (data_read_en),
    .read_index      (read_index),
    .tag_entry       (tag_entry),
    .tag_valid       (tag_valid),
    .line            (read_line),
    .resp_valid      (resp_valid),
    .resp            (resp),
    .store_hit_valid (store_hit_valid),
    .store_write     (store_write)
);

cache_write_arbiter cache_write_arbiter_inst
(
    .clk_in          (clk_in),
    .reset_in        (reset_in),
    .fill_valid      (fill_valid),
    .fill            (fill),
    .store_hit_valid (store_hit_valid),
    .store_write     (store_write),
    .tag_write_en    (tag_write_en),
    .tag_write_mask  (tag_write_mask),
    .data_write_en   (data_write_en),
    .data_write_mask (data_write_mask),
    .write_index     (write_index),
    .write_tag       (write_tag),
    .write_line      (write_line)
);

// valid array lives with the tags.
dual_port_blockram
#(
    .SINGLE_ENTRY_WIDTH_IN_BITS (`TAG_ENTRY_WIDTH),
    .NUM_SET                    (`NUM_SET),
    .SET_PTR_WIDTH_IN_BITS      (`INDEX_WIDTH),
    .WRITE_MASK_LEN             (TAG_LANES),
    .CONFIG_MODE                ("WriteFirst"),
    .WITH_VALID_REG_ARRAY       ("Yes")
)
tag_ram
(
    .clk_in                     (clk_in),
    .reset_in                   (reset_in),
    .write_port_access_en       (tag_write_en),
    .write_port_write_en        (tag_write_mask),
    .write_port_access_set_addr (write_index),
    .write_port_data            (write_tag),
    .read_port_access_en        (tag_read_en),
    .read_port_access_set_addr  (read_index),
    .read_port_data             (tag_entry),
    .read_port_valid            (tag_valid)
);

dual_port_blockram
#(
    .SINGLE_ENTRY_WIDTH_IN_BITS (`LINE_WIDTH_IN_BITS),
    .NUM_SET                    (`NUM_SET),
    .SET_PTR_WIDTH_IN_BITS      (`INDEX_WIDTH),
    .WRITE_MASK_LEN             (`LINE_BYTES),
    .CONFIG_MODE                ("WriteFirst"),
    .WITH_VALID_REG_ARRAY       ("No")
)
data_ram
(
    .clk_in                     (clk_in),
    .reset_in                   (reset_in),
    .write_port_access_en       (data_write_en),
    .write_port_write_en        (data_write_mask),
    .write_port_access_set_addr (write_index),
    .write_port_data            (write_line),
    .read_port_access_en        (data_read_en),
    .read_port_access_set_addr  (read_index),
    .read_port_data             (read_line),
    .read_port_valid            ()
);

endmodule

`default_nettype wire

// ==== verilog/cache_write_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

// fill first, then buffered store, then incoming store.
module cache_write_arbiter
(
    input  logic                                                 clk_in,
    input  logic                                                 reset_in,

    input  logic                                                 fill_valid,
    input  cache_req_pkg::cache_fill_t                           fill,

    input  logic                                                 store_hit_valid,
    input  cache_req_pkg::ram_write_t                            store_write,

    output logic                                                 tag_write_en,
    output logic [`TAG_ENTRY_WIDTH / `BYTE_LEN_IN_BITS - 1 : 0]  tag_write_mask,
    output logic                                                 data_write_en,
    output logic [`LINE_BYTES - 1 : 0]                           data_write_mask,
    output logic [`INDEX_WIDTH - 1 : 0]                          write_index,
    output cache_addr_pkg::tag_entry_t                           write_tag,
    output logic [`LINE_WIDTH_IN_BITS - 1 : 0]                   write_line
);

localparam int TAG_LANES = `TAG_ENTRY_WIDTH / `BYTE_LEN_IN_BITS;

cache_req_pkg::ram_write_t fill_write;
cache_req_pkg::ram_write_t sel_write;
cache_req_pkg::ram_write_t buf_write;
logic                      sel_valid;
logic                      buf_valid;
logic                      hold_store;

always_comb
begin
    fill_write.index     = fill.addr.fields.index;
    fill_write.tag.pad   = 1'b0;
    fill_write.tag.tag   = fill.addr.fields.tag;
    fill_write.line      = fill.line;
    fill_write.byte_en   = '1; // whole line.
    fill_write.tag_write = 1'b1;
end

always_comb
begin
    sel_valid = 1'b1;
    if (fill_valid)
        sel_write = fill_write;
    else if (buf_valid)
        sel_write = buf_write;
    else
    begin
        sel_write = store_write;
        sel_valid = store_hit_valid;
    end
end

assign data_write_en   = sel_valid;
assign data_write_mask = sel_write.byte_en;
assign tag_write_en    = sel_valid & sel_write.tag_write;
assign tag_write_mask  = {TAG_LANES{sel_write.tag_write}};
assign write_index     = sel_write.index;
assign write_tag       = sel_write.tag;
assign write_line      = sel_write.line;

// incoming store loses the port to a fill or to the buffer.
assign hold_store = store_hit_valid & (fill_valid | buf_valid);

always_ff @(posedge clk_in)
begin
    if (reset_in)
        buf_valid <= 1'b0;
    else if (hold_store)
        buf_valid <= 1'b1;
    else if (!fill_valid)
        buf_valid <= 1'b0;
end

always_ff @(posedge clk_in)
begin
    if (hold_store)
        buf_write <= store_write;
end

// a third store would overwrite the held one.
no_store_overflow : assert property (
    @(posedge clk_in) disable iff (reset_in)
    (fill_valid && buf_valid) |-> !store_hit_valid
);

endmodule

`default_nettype wire

// ==== verilog/cache_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

// stage 1 issues the ram reads, stage 2 compares tags.
module cache_lookup
(
    input  logic                                clk_in,
    input  logic                                reset_in,

    input  logic                                req_valid,
    input  cache_req_pkg::cache_req_t           req,

    output logic                                tag_read_en,
    output logic                                data_read_en,
    output logic [`INDEX_WIDTH - 1 : 0]         read_index,

    input  cache_addr_pkg::tag_entry_t          tag_entry,
    input  logic                                tag_valid,
    input  logic [`LINE_WIDTH_IN_BITS - 1 : 0]  line,

    output logic                                resp_valid,
    output cache_req_pkg::cache_resp_t          resp,

    output logic                                store_hit_valid,
    output cache_req_pkg::ram_write_t           store_write
);

logic                       s1_valid;
cache_req_pkg::cache_req_t  s1_req;
logic                       s1_hit;
logic                       s1_is_store;

// both rams are read in the request cycle.
assign tag_read_en  = req_valid;
assign data_read_en = req_valid;
assign read_index   = req.addr.fields.index;

assign s1_hit      = tag_valid & (tag_entry.tag == s1_req.addr.fields.tag);
assign s1_is_store = (s1_req.op == cache_req_pkg::CACHE_STORE);

always_ff @(posedge clk_in)
begin
    if (reset_in)
    begin
        s1_valid        <= 1'b0;
        resp_valid      <= 1'b0;
        store_hit_valid <= 1'b0;
    end
    else
    begin
        s1_valid        <= req_valid;
        resp_valid      <= s1_valid;
        store_hit_valid <= s1_valid & s1_hit & s1_is_store;
    end
end

always_ff @(posedge clk_in)
begin
    if (req_valid)
    begin
        s1_req <= req;
    end

    if (s1_valid)
    begin
        resp.hit  <= s1_hit;
        resp.addr <= s1_req.addr;
        resp.line <= line; // only meaningful for loads.

        store_write.index     <= s1_req.addr.fields.index;
        store_write.tag.pad   <= 1'b0;
        store_write.tag.tag   <= s1_req.addr.fields.tag;
        store_write.line      <= s1_req.data;
        store_write.byte_en   <= s1_req.byte_en;
        store_write.tag_write <= 1'b0;
    end
end

op_known_on_request : assert property (
    @(posedge clk_in) disable iff (reset_in)
    req_valid |-> !$isunknown(req.op)
);

endmodule

`default_nettype wire

// ==== verilog/dual_port_blockram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

// one write port, one read port, byte lane write mask.
module dual_port_blockram
#(
    parameter SINGLE_ENTRY_WIDTH_IN_BITS = 64,
    parameter NUM_SET                    = 64,
    parameter SET_PTR_WIDTH_IN_BITS      = $clog2(NUM_SET),
    parameter WRITE_MASK_LEN             = SINGLE_ENTRY_WIDTH_IN_BITS / `BYTE_LEN_IN_BITS,
    parameter CONFIG_MODE                = "WriteFirst", // ReadFirst or WriteFirst.
    parameter WITH_VALID_REG_ARRAY       = "Yes"         // Yes or No.
)
(
    input  logic                                      clk_in,
    input  logic                                      reset_in,

    input  logic                                      write_port_access_en,
    input  logic [WRITE_MASK_LEN - 1 : 0]             write_port_write_en,
    input  logic [SET_PTR_WIDTH_IN_BITS - 1 : 0]      write_port_access_set_addr,
    input  logic [SINGLE_ENTRY_WIDTH_IN_BITS - 1 : 0] write_port_data,

    input  logic                                      read_port_access_en,
    input  logic [SET_PTR_WIDTH_IN_BITS - 1 : 0]      read_port_access_set_addr,
    output logic [SINGLE_ENTRY_WIDTH_IN_BITS - 1 : 0] read_port_data,
    output logic                                      read_port_valid
);

localparam bit FORWARD_WRITE = (CONFIG_MODE == "WriteFirst");

logic [SINGLE_ENTRY_WIDTH_IN_BITS - 1 : 0] blockram [0 : NUM_SET - 1];

logic write_active;
logic read_write_collide;

generate
if (CONFIG_MODE != "WriteFirst" && CONFIG_MODE != "ReadFirst")
begin : g_bad_mode
    $error("dual_port_blockram: unknown CONFIG_MODE");
end
if (WITH_VALID_REG_ARRAY != "Yes" && WITH_VALID_REG_ARRAY != "No")
begin : g_bad_valid_option
    $error("dual_port_blockram: unknown WITH_VALID_REG_ARRAY");
end
endgenerate

// a write with an empty mask changes nothing.
assign write_active = write_port_access_en & (|write_port_write_en);

assign read_write_collide = FORWARD_WRITE
                          & read_port_access_en
                          & write_active
                          & (read_port_access_set_addr == write_port_access_set_addr);

always_ff @(posedge clk_in)
begin
    if (write_port_access_en)
    begin
        for (int lane = 0; lane < WRITE_MASK_LEN; lane++)
        begin
            if (write_port_write_en[lane])
            begin
                blockram[write_port_access_set_addr][lane * `BYTE_LEN_IN_BITS +: `BYTE_LEN_IN_BITS]
                    <= write_port_data[lane * `BYTE_LEN_IN_BITS +: `BYTE_LEN_IN_BITS];
            end
        end
    end
end

// in WriteFirst mode a colliding read gets the whole write word,
// including lanes outside the mask.
always_ff @(posedge clk_in)
begin
    if (read_write_collide)
    begin
        read_port_data <= write_port_data;
    end
    else if (read_port_access_en)
    begin
        read_port_data <= blockram[read_port_access_set_addr];
    end
end

generate
if (WITH_VALID_REG_ARRAY == "Yes")
begin : g_valid_array
    logic [NUM_SET - 1 : 0] valid_array;

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            valid_array     <= '0;
            read_port_valid <= 1'b0;
        end
        else
        begin
            if (write_active)
            begin
                valid_array[write_port_access_set_addr] <= 1'b1;
            end

            if (read_write_collide)
            begin
                read_port_valid <= 1'b1; // set becomes valid this edge.
            end
            else if (read_port_access_en)
            begin
                read_port_valid <= valid_array[read_port_access_set_addr];
            end
            else
            begin
                read_port_valid <= 1'b0;
            end
        end
    end
end
else
begin : g_no_valid_array
    // every read returns valid data.
    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            read_port_valid <= 1'b0;
        end
        else
        begin
            read_port_valid <= read_port_access_en;
        end
    end
end
endgenerate

endmodule

`default_nettype wire

// ==== verilog/cache_req_pkg.sv ====
`default_nettype none

`include "cache_consts.svh"

package cache_req_pkg;

    typedef enum logic {CACHE_LOAD = 1'b0, CACHE_STORE = 1'b1} cache_op_e;

    typedef struct packed
    {
        cache_op_e                         op;
        cache_addr_pkg::cache_addr_u       addr;
        logic [`LINE_WIDTH_IN_BITS - 1 : 0] data;    // already at line byte positions.
        logic [`LINE_BYTES - 1 : 0]        byte_en;
    } cache_req_t;

    typedef struct packed
    {
        logic                              hit;
        cache_addr_pkg::cache_addr_u       addr;
        logic [`LINE_WIDTH_IN_BITS - 1 : 0] line;
    } cache_resp_t;

    typedef struct packed
    {
        cache_addr_pkg::cache_addr_u       addr;
        logic [`LINE_WIDTH_IN_BITS - 1 : 0] line;
    } cache_fill_t;

    typedef struct packed
    {
        logic [`INDEX_WIDTH - 1 : 0]       index;
        cache_addr_pkg::tag_entry_t        tag;
        logic [`LINE_WIDTH_IN_BITS - 1 : 0] line;
        logic [`LINE_BYTES - 1 : 0]        byte_en;
        logic                              tag_write; // fills only.
    } ram_write_t;

endpackage

`default_nettype wire

// ==== verilog/cache_addr_pkg.sv ====
`default_nettype none

`include "cache_consts.svh"

package cache_addr_pkg;

    typedef struct packed
    {
        logic [`TAG_WIDTH - 1 : 0]    tag;
        logic [`INDEX_WIDTH - 1 : 0]  index;
        logic [`OFFSET_WIDTH - 1 : 0] offset;
    } cache_addr_fields_t;

    // raw word from the requester, fields for the lookup.
    typedef union packed
    {
        logic [31 : 0]      raw;
        cache_addr_fields_t fields;
    } cache_addr_u;

    // one tag ram entry.
    typedef struct packed
    {
        logic                      pad;
        logic [`TAG_WIDTH - 1 : 0] tag;
    } tag_entry_t;

endpackage

`default_nettype wire

// ==== verilog/cache_consts.svh ====
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

`define BYTE_LEN_IN_BITS    8
`define LINE_WIDTH_IN_BITS  64
`define LINE_BYTES          8
`define NUM_SET             64

// address split, tag + index + offset = 32.
`define INDEX_WIDTH         6
`define OFFSET_WIDTH        3
`define TAG_WIDTH           23

`define TAG_ENTRY_WIDTH     24 // tag padded to three byte lanes.

`endif
